// File: design/ex_pkg.sv
package ex_pkg;

    localparam int XLEN = 64;

    localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_JAL,
        UNIT_JALR,
        UNIT_MULDIV,
        UNIT_LOAD,
        UNIT_STORE
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_A,
        ALU_PASS_B
    } alu_op_e;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // M extension
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    localparam logic [1:0] MEM_NONE  = 2'd0;
    localparam logic [1:0] MEM_LOAD  = 2'd1;
    localparam logic [1:0] MEM_STORE = 2'd2;

    typedef struct packed {
        unit_e           unit;
        alu_op_e         alu_op;
        logic [2:0]      funct3;
        logic            word_op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pred_pc;
    } ex_req_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            redirect;
        logic [XLEN-1:0] target;
        logic            misaligned;
        logic [XLEN-1:0] mem_addr;
        logic [1:0]      mem_kind;
    } ex_resp_t;

endpackage

// File: design/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::ex_req_t         req,
    output logic [ex_pkg::XLEN-1:0] result
);

    logic [ex_pkg::XLEN-1:0] src1;
    logic [ex_pkg::XLEN-1:0] src2;
    logic [ex_pkg::XLEN-1:0] wide;
    logic [5:0]              shamt;
    logic                    zext;

    // In pipeline order b is rs1 and a is rs2 or the shift amount
    always_comb
    begin
        zext = (req.alu_op == ex_pkg::ALU_SRL) || (req.alu_op == ex_pkg::ALU_SLTU);
        if (req.word_op)
        begin
            // Low word widened so that the low 32 result bits come out right
            src1  = zext ? {32'b0, req.b[31:0]} : {{32{req.b[31]}}, req.b[31:0]};
            src2  = zext ? {32'b0, req.a[31:0]} : {{32{req.a[31]}}, req.a[31:0]};
            shamt = {1'b0, req.a[4:0]};
        end
        else
        begin
            src1  = req.b;
            src2  = req.a;
            shamt = req.a[5:0];
        end
    end

    always_comb
    begin
        case (req.alu_op)
            ex_pkg::ALU_ADD:    wide = src1 + src2;
            ex_pkg::ALU_SUB:    wide = src1 - src2;
            ex_pkg::ALU_SLL:    wide = src1 << shamt;
            ex_pkg::ALU_SRL:    wide = src1 >> shamt;
            ex_pkg::ALU_SRA:    wide = $unsigned($signed(src1) >>> shamt);
            ex_pkg::ALU_XOR:    wide = src1 ^ src2;
            ex_pkg::ALU_OR:     wide = src1 | src2;
            ex_pkg::ALU_AND:    wide = src1 & src2;
            ex_pkg::ALU_SLT:    wide = {{(ex_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ex_pkg::ALU_SLTU:   wide = {{(ex_pkg::XLEN-1){1'b0}}, src1 < src2};
            ex_pkg::ALU_PASS_A: wide = req.a;
            ex_pkg::ALU_PASS_B: wide = req.b;
            default:            wide = '0;
        endcase
    end

    // Word forms sign-extend bit 31
    assign result = req.word_op ? {{32{wide[31]}}, wide[31:0]} : wide;

endmodule

// File: design/ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::ex_req_t         req,
    output logic [ex_pkg::XLEN-1:0] link,
    output logic [ex_pkg::XLEN-1:0] target,
    output logic                    redirect,
    output logic                    misaligned
);

    logic                    cond;
    logic                    taken;
    logic [ex_pkg::XLEN-1:0] jump_addr;

    always_comb
    begin
        case (req.funct3)
            ex_pkg::F3_BEQ:  cond = req.a == req.b;
            ex_pkg::F3_BNE:  cond = req.a != req.b;
            ex_pkg::F3_BLT:  cond = $signed(req.a) < $signed(req.b);
            ex_pkg::F3_BGE:  cond = $signed(req.a) >= $signed(req.b);
            ex_pkg::F3_BLTU: cond = req.a < req.b;
            ex_pkg::F3_BGEU: cond = req.a >= req.b;
            default:         cond = 1'b0;
        endcase
    end

    always_comb
    begin
        taken = (req.unit == ex_pkg::UNIT_BRANCH) ? cond :
                (req.unit == ex_pkg::UNIT_JAL) || (req.unit == ex_pkg::UNIT_JALR);
        if (req.unit == ex_pkg::UNIT_JALR)
            jump_addr = (req.a + req.imm) & ~ex_pkg::XLEN'(1);
        else
            jump_addr = req.pc + req.imm;
    end

    assign link       = req.pc + ex_pkg::PC_STEP;
    assign target     = taken ? jump_addr : link;
    // Front end guessed wrong
    assign redirect   = target != req.pred_pc;
    assign misaligned = taken && jump_addr[1];

endmodule

// File: design/ex_agu.sv
`timescale 1ns/1ps

module ex_agu (
    input  ex_pkg::ex_req_t         req,
    output logic [ex_pkg::XLEN-1:0] addr,
    output logic                    misaligned
);

    logic [2:0] size_mask;

    assign addr = req.a + req.imm;

    // Byte, half, word, double
    always_comb
    begin
        case (req.funct3[1:0])
            2'd0:    size_mask = 3'b000;
            2'd1:    size_mask = 3'b001;
            2'd2:    size_mask = 3'b011;
            default: size_mask = 3'b111;
        endcase
    end

    // Natural alignment only
    assign misaligned = |(addr[2:0] & size_mask);

endmodule

// File: design/ex_muldiv.sv
`timescale 1ns/1ps

module ex_muldiv (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    start,
    input  logic [2:0]              funct3,
    input  logic                    word_op,
    input  logic [ex_pkg::XLEN-1:0] a,
    input  logic [ex_pkg::XLEN-1:0] b,
    output logic                    busy,
    output logic                    done,
    output logic [ex_pkg::XLEN-1:0] result
);

    localparam int W  = ex_pkg::XLEN;
    localparam int CW = $clog2(W + 1);

    // a is rs1 (multiplicand, dividend), b is rs2
    logic           is_div, a_sgn, b_sgn, a_neg, b_neg;
    logic           div_zero, div_ovf;
    logic [W-1:0]   a_x, b_x, a_mag, b_mag, min_neg, spec_val;

    logic           special_q, word_q, neg_q;
    logic [2:0]     f3_q;
    logic [CW-1:0]  cnt_q;
    logic [W-1:0]   hi_q;
    logic [W-1:0]   lo_q, opb_q;

    logic [W:0]     mul_sum, rem_sh, rem_dif;
    logic [2*W-1:0] prod, prod_s;
    logic [W-1:0]   quo_s, rem_s, raw, fin;
    logic           last;

    ////////////////////////////////////////
    // Operand setup
    ////////////////////////////////////////
    always_comb
    begin
        is_div   = funct3[2];
        a_sgn    = is_div ? !funct3[0] : (funct3[1:0] != 2'b11);
        b_sgn    = is_div ? !funct3[0] : !funct3[1];
        a_x      = !word_op ? a : (a_sgn ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]});
        b_x      = !word_op ? b : (b_sgn ? {{32{b[31]}}, b[31:0]} : {32'b0, b[31:0]});
        a_neg    = a_sgn && a_x[W-1];
        b_neg    = b_sgn && b_x[W-1];
        a_mag    = a_neg ? -a_x : a_x;
        b_mag    = b_neg ? -b_x : b_x;
        min_neg  = word_op ? {{(W-31){1'b1}}, 31'b0} : {1'b1, {(W-1){1'b0}}};
        div_zero = is_div && (b_x == '0);
        div_ovf  = is_div && !funct3[0] && (a_x == min_neg) && (&b_x);
        // Quotient or remainder fixed by the spec
        if (div_zero)
            spec_val = funct3[1] ? a_x : '1;
        else
            spec_val = funct3[1] ? '0 : a_x;
    end

    ////////////////////////////////////////
    // Iteration step
    ////////////////////////////////////////
    always_comb
    begin
        mul_sum = {1'b0, hi_q} + ({(W+1){lo_q[0]}} & {1'b0, opb_q});
        rem_sh  = {hi_q, lo_q[W-1]};
        rem_dif = rem_sh - {1'b0, opb_q};
        last    = busy && (special_q || (cnt_q == CW'(W)));
    end

    // Sign fix-up and word formatting
    always_comb
    begin
        prod   = {hi_q, lo_q};
        prod_s = neg_q ? -prod : prod;
        quo_s  = neg_q ? -lo_q : lo_q;
        rem_s  = neg_q ? -hi_q : hi_q;
        if (special_q)
            raw = lo_q;
        else if (f3_q[2])
            raw = f3_q[1] ? rem_s : quo_s;
        else if (f3_q == ex_pkg::F3_MUL)
            raw = prod_s[W-1:0];
        else
            raw = prod_s[2*W-1:W];
        fin = word_q ? {{32{raw[31]}}, raw[31:0]} : raw;
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            busy      <= 1'b0;
            done      <= 1'b0;
            special_q <= 1'b0;
            cnt_q     <= '0;
        end
        else
        begin
            done <= last;
            if (start)
            begin
                busy      <= 1'b1;
                special_q <= div_zero || div_ovf;
                cnt_q     <= '0;
            end
            else if (last)
                busy <= 1'b0;
            else if (busy)
                cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            f3_q   <= funct3;
            word_q <= word_op;
            neg_q  <= (is_div && funct3[1]) ? a_neg : (a_neg ^ b_neg);
            hi_q   <= '0;
            lo_q   <= (div_zero || div_ovf) ? spec_val : a_mag;
            opb_q  <= b_mag;
        end
        else if (busy && !last)
        begin
            if (f3_q[2])
            begin
                // Restoring divide shifts the quotient into lo
                hi_q <= rem_dif[W] ? rem_sh[W-1:0] : rem_dif[W-1:0];
                lo_q <= {lo_q[W-2:0], !rem_dif[W]};
            end
            else
            begin
                hi_q <= mul_sum[W:1];
                lo_q <= {mul_sum[0], lo_q[W-1:1]};
            end
        end
        if (last)
            result <= fin;
    end

    // Issue side must hold off until the result is out
    a_start_idle: assert property (@(posedge CLK) disable iff (RST)
        start |-> !busy && !done);

endmodule

// File: design/ex_result_reg.sv
`timescale 1ns/1ps

module ex_result_reg (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    in_valid,
    input  ex_pkg::ex_req_t         in_req,
    output logic                    in_ready,
    input  logic [ex_pkg::XLEN-1:0] alu_result,
    input  logic [ex_pkg::XLEN-1:0] br_link,
    input  logic [ex_pkg::XLEN-1:0] br_target,
    input  logic                    br_redirect,
    input  logic                    br_misaligned,
    input  logic [ex_pkg::XLEN-1:0] agu_addr,
    input  logic                    agu_misaligned,
    input  logic                    md_busy,
    input  logic                    md_done,
    input  logic [ex_pkg::XLEN-1:0] md_result,
    output logic                    md_start,
    output logic                    out_valid,
    output ex_pkg::ex_resp_t        out_resp,
    input  logic                    out_ready
);

    logic             accept;
    logic             is_md;
    ex_pkg::ex_resp_t resp_d;

    // Free when empty or draining, and no multiply/divide in progress
    assign in_ready = (!out_valid || out_ready) && !md_busy && !md_done;
    assign accept   = in_valid && in_ready;
    assign is_md    = in_req.unit == ex_pkg::UNIT_MULDIV;
    assign md_start = accept && is_md;

    always_comb
    begin
        resp_d        = '0;
        resp_d.target = in_req.pc + ex_pkg::PC_STEP;
        case (in_req.unit)
            ex_pkg::UNIT_ALU:
                resp_d.data = alu_result;
            ex_pkg::UNIT_BRANCH, ex_pkg::UNIT_JAL, ex_pkg::UNIT_JALR:
            begin
                resp_d.data       = br_link;
                resp_d.target     = br_target;
                resp_d.redirect   = br_redirect;
                resp_d.misaligned = br_misaligned;
            end
            ex_pkg::UNIT_LOAD, ex_pkg::UNIT_STORE:
            begin
                resp_d.mem_addr   = agu_addr;
                resp_d.misaligned = agu_misaligned;
                resp_d.mem_kind   = (in_req.unit == ex_pkg::UNIT_LOAD) ?
                                    ex_pkg::MEM_LOAD : ex_pkg::MEM_STORE;
            end
            default:
                resp_d.data = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
            out_valid <= 1'b0;
        else if (md_done)
            out_valid <= 1'b1;
        else if (accept)
            out_valid <= !is_md;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // MULDIV keeps the shell from issue and takes its data at done
    always_ff @(posedge CLK)
    begin
        if (accept)
            out_resp <= resp_d;
        if (md_done)
            out_resp.data <= md_result;
    end

    a_hold_resp: assert property (@(posedge CLK) disable iff (RST)
        out_valid && !out_ready |=> out_valid && $stable(out_resp));

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic             CLK,
    input  logic             RST,
    input  logic             in_valid,
    input  ex_pkg::ex_req_t  in_req,
    output logic             in_ready,
    output logic             out_valid,
    output ex_pkg::ex_resp_t out_resp,
    input  logic             out_ready
);

    logic [ex_pkg::XLEN-1:0] alu_result, br_link, br_target, agu_addr, md_result;
    logic                    br_redirect, br_misaligned, agu_misaligned;
    logic                    md_start, md_busy, md_done;

    ex_alu u_alu (.req(in_req), .result(alu_result));

    ex_branch u_branch (.req(in_req), .link(br_link), .target(br_target),
        .redirect(br_redirect), .misaligned(br_misaligned));

    ex_agu u_agu (.req(in_req), .addr(agu_addr), .misaligned(agu_misaligned));

    // In pipeline order b carries rs1
    ex_muldiv u_muldiv (.CLK(CLK), .RST(RST), .start(md_start), .funct3(in_req.funct3),
        .word_op(in_req.word_op), .a(in_req.b), .b(in_req.a), .busy(md_busy),
        .done(md_done), .result(md_result));

    ex_result_reg u_result_reg (.CLK(CLK), .RST(RST), .in_valid(in_valid),
        .in_req(in_req), .in_ready(in_ready), .alu_result(alu_result),
        .br_link(br_link), .br_target(br_target), .br_redirect(br_redirect),
        .br_misaligned(br_misaligned), .agu_addr(agu_addr),
        .agu_misaligned(agu_misaligned), .md_busy(md_busy), .md_done(md_done),
        .md_result(md_result), .md_start(md_start), .out_valid(out_valid),
        .out_resp(out_resp), .out_ready(out_ready));

endmodule

// File: dv/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int XL          = ex_pkg::XLEN;
    localparam int ISSUE_LIMIT = 20;
    localparam int RESP_LIMIT  = 2 * ex_pkg::XLEN + 10;

    logic             CLK;
    logic             RST;
    logic             in_valid;
    ex_pkg::ex_req_t  in_req;
    logic             in_ready;
    logic             out_valid;
    ex_pkg::ex_resp_t out_resp;
    logic             out_ready;

    int          err_count   = 0;
    int          check_count = 0;
    int          pass_tests  = 0;
    int          fail_tests  = 0;
    logic [31:0] lcg_state   = 32'hdad1_241e;

    ex_stage dut (
        .CLK       (CLK),
        .RST       (RST),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_resp  (out_resp),
        .out_ready (out_ready)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [XL-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic logic [XL-1:0] edge_val(input int k);
        case (k)
            3:       return 64'h8000_0000_0000_0000;
            4:       return 64'h0000_0000_0000_003f;
            5:       return 64'hffff_ffff_ffff_ffff;
            6:       return 64'h7fff_ffff_ffff_ffff;
            7:       return 64'h0000_0000_8000_0000;
            default: return 64'h0000_0000_0000_0020;
        endcase
    endfunction

    function automatic ex_pkg::ex_req_t make_req(input ex_pkg::unit_e unit,
        input ex_pkg::alu_op_e op, input logic [2:0] f3, input logic word,
        input logic [XL-1:0] a, input logic [XL-1:0] b, input logic [XL-1:0] imm,
        input logic [XL-1:0] pc, input logic [XL-1:0] pred);
        ex_pkg::ex_req_t r;
        r.unit    = unit;
        r.alu_op  = op;
        r.funct3  = f3;
        r.word_op = word;
        r.a       = a;
        r.b       = b;
        r.imm     = imm;
        r.pc      = pc;
        r.pred_pc = pred;
        return r;
    endfunction

    ////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////
    function automatic logic [XL-1:0] alu_model(input ex_pkg::ex_req_t q);
        logic [XL-1:0] x;
        logic [XL-1:0] y;
        logic [XL-1:0] r;
        logic [31:0]   xw;
        logic [31:0]   yw;
        logic [31:0]   rw;
        // Source 1 is b, source 2 is a
        x  = q.b;
        y  = q.a;
        xw = q.b[31:0];
        yw = q.a[31:0];
        case (q.alu_op)
            ex_pkg::ALU_ADD:    r = x + y;
            ex_pkg::ALU_SUB:    r = x - y;
            ex_pkg::ALU_SLL:    r = x << y[5:0];
            ex_pkg::ALU_SRL:    r = x >> y[5:0];
            ex_pkg::ALU_SRA:    r = $signed(x) >>> y[5:0];
            ex_pkg::ALU_XOR:    r = x ^ y;
            ex_pkg::ALU_OR:     r = x | y;
            ex_pkg::ALU_AND:    r = x & y;
            ex_pkg::ALU_SLT:    r = {63'b0, $signed(x) < $signed(y)};
            ex_pkg::ALU_SLTU:   r = {63'b0, x < y};
            ex_pkg::ALU_PASS_A: r = q.a;
            ex_pkg::ALU_PASS_B: r = q.b;
            default:            r = '0;
        endcase
        case (q.alu_op)
            ex_pkg::ALU_ADD:    rw = xw + yw;
            ex_pkg::ALU_SUB:    rw = xw - yw;
            ex_pkg::ALU_SLL:    rw = xw << yw[4:0];
            ex_pkg::ALU_SRL:    rw = xw >> yw[4:0];
            ex_pkg::ALU_SRA:    rw = $signed(xw) >>> yw[4:0];
            ex_pkg::ALU_XOR:    rw = xw ^ yw;
            ex_pkg::ALU_OR:     rw = xw | yw;
            ex_pkg::ALU_AND:    rw = xw & yw;
            ex_pkg::ALU_SLT:    rw = {31'b0, $signed(xw) < $signed(yw)};
            ex_pkg::ALU_SLTU:   rw = {31'b0, xw < yw};
            ex_pkg::ALU_PASS_A: rw = yw;
            ex_pkg::ALU_PASS_B: rw = xw;
            default:            rw = '0;
        endcase
        return q.word_op ? {{32{rw[31]}}, rw} : r;
    endfunction

    function automatic ex_pkg::ex_resp_t branch_model(input ex_pkg::ex_req_t q);
        ex_pkg::ex_resp_t e;
        logic             cond;
        logic             jump;
        logic [XL-1:0]    dest;
        logic [XL-1:0]    next_pc;
        case (q.funct3)
            ex_pkg::F3_BEQ:  cond = q.a == q.b;
            ex_pkg::F3_BNE:  cond = q.a != q.b;
            ex_pkg::F3_BLT:  cond = $signed(q.a) < $signed(q.b);
            ex_pkg::F3_BGE:  cond = $signed(q.a) >= $signed(q.b);
            ex_pkg::F3_BLTU: cond = q.a < q.b;
            ex_pkg::F3_BGEU: cond = q.a >= q.b;
            default:         cond = 1'b0;
        endcase
        jump    = (q.unit != ex_pkg::UNIT_BRANCH) || cond;
        dest    = (q.unit == ex_pkg::UNIT_JALR) ? (q.a + q.imm) & ~64'd1 : q.pc + q.imm;
        next_pc = jump ? dest : q.pc + 64'd4;
        e            = '0;
        e.data       = q.pc + 64'd4;
        e.target     = next_pc;
        e.redirect   = next_pc != q.pred_pc;
        e.misaligned = jump && dest[1];
        return e;
    endfunction

    function automatic ex_pkg::ex_resp_t mem_model(input ex_pkg::ex_req_t q);
        ex_pkg::ex_resp_t e;
        logic [XL-1:0]    addr;
        logic [2:0]       low_mask;
        addr     = q.a + q.imm;
        low_mask = 3'((1 << q.funct3[1:0]) - 1);
        e            = '0;
        e.target     = q.pc + 64'd4;
        e.misaligned = |(addr[2:0] & low_mask);
        e.mem_addr   = addr;
        e.mem_kind   = (q.unit == ex_pkg::UNIT_LOAD) ? ex_pkg::MEM_LOAD : ex_pkg::MEM_STORE;
        return e;
    endfunction

    function automatic logic [XL-1:0] md_model(input logic [2:0] f3, input logic word,
        input logic [XL-1:0] src1, input logic [XL-1:0] src2);
        logic            sgn1;
        logic            sgn2;
        logic [XL-1:0]   x;
        logic [XL-1:0]   y;
        logic [XL-1:0]   min_neg;
        logic [XL-1:0]   quo;
        logic [XL-1:0]   rem;
        logic [XL-1:0]   res;
        logic [2*XL-1:0] p;
        sgn1    = f3[2] ? !f3[0] : (f3[1:0] != 2'b11);
        sgn2    = f3[2] ? !f3[0] : !f3[1];
        x       = src1;
        y       = src2;
        min_neg = word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
        if (word)
        begin
            x = sgn1 ? {{32{src1[31]}}, src1[31:0]} : {32'b0, src1[31:0]};
            y = sgn2 ? {{32{src2[31]}}, src2[31:0]} : {32'b0, src2[31:0]};
        end
        p = {{XL{sgn1 & x[XL-1]}}, x} * {{XL{sgn2 & y[XL-1]}}, y};
        if (y == '0)
        begin
            quo = '1;
            rem = x;
        end
        else if (sgn1 && x == min_neg && y == '1)
        begin
            quo = x;
            rem = '0;
        end
        else if (sgn1)
        begin
            quo = $signed(x) / $signed(y);
            rem = $signed(x) % $signed(y);
        end
        else
        begin
            quo = x / y;
            rem = x % y;
        end
        if (f3[2])
            res = f3[1] ? rem : quo;
        else
            res = (f3 == ex_pkg::F3_MUL) ? p[XL-1:0] : p[2*XL-1:XL];
        return word ? {{32{res[31]}}, res[31:0]} : res;
    endfunction

    function automatic ex_pkg::ex_resp_t expect_resp(input ex_pkg::ex_req_t q);
        ex_pkg::ex_resp_t e;
        e        = '0;
        e.target = q.pc + 64'd4;
        case (q.unit)
            ex_pkg::UNIT_ALU:
                e.data = alu_model(q);
            ex_pkg::UNIT_MULDIV:
                e.data = md_model(q.funct3, q.word_op, q.b, q.a);
            ex_pkg::UNIT_LOAD, ex_pkg::UNIT_STORE:
                e = mem_model(q);
            default:
                e = branch_model(q);
        endcase
        return e;
    endfunction

    ////////////////////////////////////////
    // Checking and handshakes
    ////////////////////////////////////////
    task automatic report_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic check_val(input string name, input logic [XL-1:0] got,
        input logic [XL-1:0] want);
        check_count++;
        assert (got === want)
        else
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
            err_count++;
        end
    endtask

    task automatic check_resp(input ex_pkg::ex_resp_t got, input ex_pkg::ex_resp_t want);
        check_val("out_resp.data", got.data, want.data);
        check_val("out_resp.target", got.target, want.target);
        check_val("out_resp.redirect", got.redirect, want.redirect);
        check_val("out_resp.misaligned", got.misaligned, want.misaligned);
        check_val("out_resp.mem_addr", got.mem_addr, want.mem_addr);
        check_val("out_resp.mem_kind", got.mem_kind, want.mem_kind);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            pass_tests++;
            $display("test %s passed", name);
        end
        else
        begin
            fail_tests++;
            $display("test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // Issue one request and compare its response
    task automatic exec(input ex_pkg::ex_req_t req);
        ex_pkg::ex_resp_t want;
        bit               accepted;
        bit               is_md;
        int               n;
        want     = expect_resp(req);
        is_md    = req.unit == ex_pkg::UNIT_MULDIV;
        @(negedge CLK);
        in_valid = 1'b1;
        in_req   = req;
        accepted = in_ready;
        n        = 0;
        while (!accepted && n < ISSUE_LIMIT)
        begin
            @(negedge CLK);
            accepted = in_ready;
            n++;
        end
        @(negedge CLK);
        in_valid = 1'b0;
        n        = 1;
        while (accepted && !out_valid && n < RESP_LIMIT)
        begin
            assert (!in_ready)
            else report_failure("in_ready went high before the multiply/divide response");
            @(negedge CLK);
            n++;
        end
        if (!accepted)
            report_failure("request was not accepted before the timeout");
        else if (!out_valid)
            report_failure("no response arrived before the timeout");
        else
        begin
            assert (is_md || n == 1)
            else report_failure("response did not arrive one cycle after acceptance");
            check_resp(out_resp, want);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset();
        int errs;
        errs = err_count;
        @(negedge CLK);
        check_val("out_valid", out_valid, 1'b0);
        check_val("in_ready", in_ready, 1'b1);
        finish_test("reset", errs);
    endtask

    task automatic test_alu();
        logic [XL-1:0] a;
        logic [XL-1:0] b;
        logic [XL-1:0] pc;
        int            errs;
        errs = err_count;
        for (int op = 0; op < 12; op++)
        begin
            for (int w = 0; w < 2; w++)
            begin
                for (int k = 0; k < 6; k++)
                begin
                    a  = (k < 3) ? rand64() : edge_val(k);
                    b  = (k < 3) ? rand64() : edge_val(k + 3);
                    pc = rand64() & ~64'h3;
                    exec(make_req(ex_pkg::UNIT_ALU, ex_pkg::alu_op_e'(op), 3'b000, 1'(w),
                        a, b, 64'h0, pc, pc + 64'd4));
                end
            end
        end
        finish_test("alu", errs);
    endtask

    task automatic test_branch();
        logic [XL-1:0] a;
        logic [XL-1:0] b;
        logic [XL-1:0] imm;
        logic [XL-1:0] pc;
        logic [XL-1:0] pred;
        logic [31:0]   r;
        int            errs;
        errs = err_count;
        for (int f3 = 0; f3 < 8; f3++)
        begin
            // 3'b010 and 3'b011 are not branch conditions
            if (f3 == 2 || f3 == 3)
                continue;
            for (int k = 0; k < 4; k++)
            begin
                r   = lcg_next();
                pc  = rand64() & ~64'h3;
                imm = {{51{r[12]}}, r[12:2], 2'b00};
                a   = rand64();
                b   = (k == 0) ? a : rand64();
                // Signed and unsigned order disagree
                if (k == 2)
                begin
                    a[63] = 1'b1;
                    b[63] = 1'b0;
                end
                pred = k[0] ? pc + imm : pc + 64'd4;
                exec(make_req(ex_pkg::UNIT_BRANCH, ex_pkg::ALU_ADD, 3'(f3), 1'b0,
                    a, b, imm, pc, pred));
            end
        end
        // Odd k puts bit 1 into the target
        for (int k = 0; k < 4; k++)
        begin
            r   = lcg_next();
            pc  = rand64() & ~64'h3;
            a   = rand64() & ~64'h3;
            imm = {{51{r[12]}}, r[12:2], k[0], 1'b0};
            if (k < 2)
            begin
                pred = (k == 0) ? pc + imm : pc + 64'd4;
                exec(make_req(ex_pkg::UNIT_JAL, ex_pkg::ALU_ADD, 3'b000, 1'b0,
                    a, 64'h0, imm, pc, pred));
            end
            else
            begin
                pred = (k == 2) ? a + imm : rand64();
                if (k == 3)
                    a[0] = 1'b1;
                exec(make_req(ex_pkg::UNIT_JALR, ex_pkg::ALU_ADD, 3'b000, 1'b0,
                    a, 64'h0, imm, pc, pred));
            end
        end
        finish_test("branch", errs);
    endtask

    task automatic test_mem();
        logic [XL-1:0] a;
        logic [XL-1:0] imm;
        logic [XL-1:0] pc;
        logic [31:0]   r;
        int            errs;
        errs = err_count;
        for (int u = 0; u < 2; u++)
        begin
            for (int sz = 0; sz < 4; sz++)
            begin
                for (int k = 0; k < 4; k++)
                begin
                    r   = lcg_next();
                    a   = rand64();
                    imm = {{52{r[11]}}, r[11:0]};
                    pc  = rand64() & ~64'h3;
                    if (k == 0)
                    begin
                        a   = a & ~64'h7;
                        imm = imm & ~64'h7;
                    end
                    exec(make_req(u ? ex_pkg::UNIT_STORE : ex_pkg::UNIT_LOAD,
                        ex_pkg::ALU_ADD, {r[12], 2'(sz)}, 1'b0, a, 64'h0, imm,
                        pc, pc + 64'd4));
                end
            end
        end
        finish_test("load_store", errs);
    endtask

    task automatic test_muldiv();
        logic [XL-1:0] a;
        logic [XL-1:0] b;
        logic [XL-1:0] pc;
        int            errs;
        errs = err_count;
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int w = 0; w < 2; w++)
            begin
                for (int k = 0; k < 4; k++)
                begin
                    // b is the dividend, a the divisor
                    a  = rand64();
                    b  = rand64();
                    pc = rand64() & ~64'h3;
                    if (k == 1)
                        a = a >> 40;
                    else if (k == 2)
                        a = '0;
                    else if (k == 3)
                    begin
                        a = '1;
                        b = w ? 64'h0000_0001_8000_0000 : 64'h8000_0000_0000_0000;
                    end
                    exec(make_req(ex_pkg::UNIT_MULDIV, ex_pkg::ALU_ADD, 3'(f3), 1'(w),
                        a, b, 64'h0, pc, pc + 64'd4));
                end
            end
        end
        finish_test("muldiv", errs);
    endtask

    task automatic test_backpressure();
        ex_pkg::ex_req_t  first;
        ex_pkg::ex_req_t  second;
        ex_pkg::ex_resp_t held;
        int               errs;
        errs   = err_count;
        first  = make_req(ex_pkg::UNIT_ALU, ex_pkg::ALU_ADD, 3'b000, 1'b0,
            rand64(), rand64(), 64'h0, 64'h1000, 64'h1004);
        second = make_req(ex_pkg::UNIT_ALU, ex_pkg::ALU_XOR, 3'b000, 1'b0,
            rand64(), rand64(), 64'h0, 64'h1004, 64'h1008);
        @(negedge CLK);
        out_ready = 1'b0;
        exec(first);
        held     = out_resp;
        in_valid = 1'b1;
        in_req   = second;
        repeat (4)
        begin
            @(negedge CLK);
            assert (out_valid)
            else report_failure("out_valid dropped while the response was held");
            assert (!in_ready)
            else report_failure("in_ready stayed high with the response register full");
            check_resp(out_resp, held);
        end
        // First drains and second is taken on the same edge
        out_ready = 1'b1;
        @(negedge CLK);
        in_valid = 1'b0;
        assert (out_valid)
        else report_failure("queued request gave no response after release");
        check_resp(out_resp, expect_resp(second));
        @(negedge CLK);
        assert (!out_valid)
        else report_failure("extra response after the queued requests");
        finish_test("backpressure", errs);
    endtask

    initial
    begin
        RST       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        test_reset();
        test_alu();
        test_branch();
        test_mem();
        test_muldiv();
        test_backpressure();
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
            pass_tests, fail_tests, check_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: ex_stage.f
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_agu.sv
design/ex_muldiv.sv
design/ex_result_reg.sv
design/ex_stage.sv
dv/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - design/ex_pkg.sv
  - design/ex_alu.sv
  - design/ex_branch.sv
  - design/ex_agu.sv
  - design/ex_muldiv.sv
  - design/ex_result_reg.sv
  - design/ex_stage.sv
  - target: simulation
    files:
      - dv/tb_ex_stage.sv
